//--- tb_input.txt
# addr rdN dqmN memDi smpcDo scuDo memWaitN scuWaitN, then expected sel cpuDi cpuWaitN
# all hex; sel bits are romCsN sramCsN smpcCsN ramlCsN ramhCsN from high to low
0000000 1 F 11111111 A5 22222222 1 1 1F 22222222 1
0080000 1 F 11111111 A5 22222222 0 1 1F 22222222 1
0000100 0 F 12345678 A5 CAFEF00D 1 1 0F 12345678 1
0080004 0 F 0BADBEEF 3C 55555555 0 1 0F 0BADBEEF 0
0100020 0 F 11111111 3C 55555555 1 1 1B 3C3C3C3C 1
0100021 0 F 11111111 81 55555555 0 1 1B 81818181 1
010007F 0 F 11111111 7E 55555555 1 0 1B 7E7E7E7E 0
0180010 1 E DEADBEEF 00 66666666 1 1 17 DEADBEEF 1
01FFFFC 1 0 01020304 00 66666666 0 1 17 01020304 0
0200000 0 F 89ABCDEF 12 77777777 1 1 1D 89ABCDEF 1
02FFFF0 1 C 13579BDF 12 77777777 0 0 1D 13579BDF 0
0300000 0 F 13579BDF 12 76543210 0 1 1F 76543210 1
1F80000 1 7 AAAAAAAA 12 0F0F0F0F 1 0 1F 0F0F0F0F 0
2000000 0 F AAAAAAAA 12 01234567 0 1 1F 01234567 1
4123456 1 B AAAAAAAA 12 FEDCBA98 1 1 1F FEDCBA98 1
6000000 0 F 11223344 99 BBBBBBBB 1 1 1E 11223344 1
7FFFFFC 1 8 55667788 99 BBBBBBBB 0 1 1E 55667788 0
6100000 0 F 99AABBCC 99 BBBBBBBB 0 0 1E 99AABBCC 0
6000000 1 F 99AABBCC 99 BBBBBBBB 0 0 1F BBBBBBBB 0

//--- project.f
+incdir+.
saturnPkg.sv
cpuBusIf.sv
clockEnableGen.sv
cpuBusDecoder.sv
debugMonitor.sv
saturnGlue.sv
saturnGlue_chk.sv
tb_saturnGlue.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_saturnGlue -f project.f -o simv
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAILED" sim.log; then
	exit 1
fi

//--- tb_saturnGlue.sv
`timescale 1ns/100ps
`include "saturn_consts.svh"

module tb_saturnGlue;
	import saturnPkg::*;

	localparam int NFIELD = 11;

	logic      CLK, RST_N, ce, dbgPause, cpuRdN, memWaitN, scuWaitN;
	logic      cpuWaitN, memRdN, ceR, ceF, smpcCe, mresN, dbgHook;
	logic      romCsN, sramCsN, smpcCsN, ramlCsN, ramhCsN;
	cpuAddr_t  cpuAddr;
	busData_t  cpuDo, cpuDi, memDi, memDo, scuDo;
	dqm_t      cpuDqmN, memDqmN;
	busAddr_t  memA;
	smpcData_t smpcDo;
	dbgCount_t waitCnt;

	// Reference model state
	logic        mPhase, mSmpc, mMres, mHook;
	int          mCnt;
	dbgCount_t   mWait;
	logic [31:0] vecQ[$];
	int          numVec;
	bit          loaded = 1'b0;

	saturnGlue u_dut (.*);

	bind saturnGlue saturnGlue_chk u_chk (
		.CLK(CLK), .RST_N(RST_N), .romCsN(romCsN), .sramCsN(sramCsN), .smpcCsN(smpcCsN),
		.ramlCsN(ramlCsN), .ramhCsN(ramhCsN), .ceR(ceR), .ceF(ceF), .mresN(mresN)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			failRun($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic checkData(input string name, input busData_t got, input busData_t exp);
		if (got !== exp) begin
			failRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic checkCount(input string name, input dbgCount_t got, input dbgCount_t exp);
		if (got !== exp) begin
			failRun($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
		end
	endtask

	task automatic checkAddr(input string name, input busAddr_t got, input busAddr_t exp);
		if (got !== exp) begin
			failRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic checkDqm(input string name, input dqm_t got, input dqm_t exp);
		if (got !== exp) begin
			failRun($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic loadVectors();
		int          fd;
		int          n;
		string       line;
		logic [31:0] fld [NFIELD];
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0) begin
			failRun("could not open tb_input.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0 && line.substr(0, 0) != "#") begin
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", fld[0], fld[1],
						fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8], fld[9], fld[10]);
					if (n == NFIELD) begin
						foreach (fld[k]) vecQ.push_back(fld[k]);
					end
				end
			end
			$fclose(fd);
			numVec = vecQ.size() / NFIELD;
			loaded = 1'b1;
		end
	endtask

	// Inputs are already driven; check the clocked outputs, then step the model one clock
	task automatic checkCycle();
		logic run;
		logic expR;
		run  = ce & ~dbgPause;
		expR = run & mPhase;
		#1;
		checkBit("ceR", ceR, expR);
		checkBit("ceF", ceF, run & ~mPhase);
		checkBit("smpcCe", smpcCe, mSmpc);
		checkBit("mresN", mresN, mMres);
		checkCount("waitCnt", waitCnt, mWait);
		checkBit("dbgHook", dbgHook, mHook);
		mMres = mMres | mSmpc;
		mSmpc = 1'b0;
		if (expR) begin
			mCnt++;
			if (mCnt == `SMPC_DIV) begin
				mCnt  = 0;
				mSmpc = 1'b1;
			end
			if (!cpuRdN || cpuDqmN != '1) begin
				mWait = '0;
			end else begin
				mWait = mWait + dbgCount_t'(1);
			end
			if (!cpuRdN && cpuAddr[`AREA_HI:`AREA_LO] == `AREA_CS3 &&
			    cpuAddr[`BUS_ADDR_W-1:0] == `HOOK_ADDR) begin
				mHook = 1'b1;
			end
		end
		if (run) begin
			mPhase = ~mPhase;
		end
	endtask

	always @(negedge CLK) begin
		if (u_dut.u_chk.selFail || u_dut.u_chk.ceFail || u_dut.u_chk.mresFail) begin
			failRun("an assertion in saturnGlue_chk failed");
		end
	end

	initial begin
		wait (loaded);
		#(8 * (20 * numVec + 2000));
		failRun("timeout: the run did not finish in time");
	end

	initial begin
		void'($urandom(45));
		RST_N    = 1'b0;
		ce       = 1'b0;
		dbgPause = 1'b0;
		cpuAddr  = '0;
		cpuDo    = '0;
		cpuDqmN  = '1;
		cpuRdN   = 1'b1;
		memDi    = '0;
		memWaitN = 1'b1;
		smpcDo   = '0;
		scuDo    = '0;
		scuWaitN = 1'b1;
		mPhase   = 1'b0;
		mSmpc    = 1'b0;
		mMres    = 1'b0;
		mHook    = 1'b0;
		mCnt     = 0;
		mWait    = '0;
		loadVectors();
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;

		// Bus decode, read select, wait combine and memory side from the file
		for (int i = 0; i < numVec; i++) begin
			int b;
			b = i * NFIELD;
			@(negedge CLK);
			cpuAddr  = vecQ[b][`CPU_ADDR_W-1:0];
			cpuRdN   = vecQ[b + 1][0];
			cpuDqmN  = vecQ[b + 2][`DQM_W-1:0];
			memDi    = vecQ[b + 3];
			smpcDo   = vecQ[b + 4][`SMPC_W-1:0];
			scuDo    = vecQ[b + 5];
			memWaitN = vecQ[b + 6][0];
			scuWaitN = vecQ[b + 7][0];
			cpuDo    = $urandom();
			checkCycle();
			checkBit("romCsN", romCsN, vecQ[b + 8][4]);
			checkBit("sramCsN", sramCsN, vecQ[b + 8][3]);
			checkBit("smpcCsN", smpcCsN, vecQ[b + 8][2]);
			checkBit("ramlCsN", ramlCsN, vecQ[b + 8][1]);
			checkBit("ramhCsN", ramhCsN, vecQ[b + 8][0]);
			checkData("cpuDi", cpuDi, vecQ[b + 9]);
			checkBit("cpuWaitN", cpuWaitN, vecQ[b + 10][0]);
			checkAddr("memA", memA, vecQ[b][`BUS_ADDR_W-1:0]);
			checkData("memDo", memDo, cpuDo);
			checkDqm("memDqmN", memDqmN, vecQ[b + 2][`DQM_W-1:0]);
			checkBit("memRdN", memRdN, vecQ[b + 1][0]);
		end

		// Clock enables with random ce and one pause window
		for (int i = 0; i < 500; i++) begin
			@(negedge CLK);
			cpuRdN   = 1'b1;
			cpuDqmN  = '1;
			dbgPause = (i >= 200) && (i < 240);
			ce       = dbgPause || (($urandom % 3) != 0);
			checkCycle();
		end
		checkBit("mresN", mresN, 1'b1);

		// Idle counter and boot hook
		for (int i = 0; i < 300; i++) begin
			@(negedge CLK);
			dbgPause = 1'b0;
			ce       = ($urandom % 2) != 0;
			cpuRdN   = 1'b1;
			cpuDqmN  = '1;
			if (i >= 100 && i < 110) begin
				cpuAddr = {`AREA_CS3, `HOOK_ADDR + 25'd4};
				cpuRdN  = 1'b0;
			end else if (i >= 150 && i < 160) begin
				cpuAddr = {`AREA_CS3, `HOOK_ADDR};
				cpuRdN  = 1'b0;
				ce      = 1'b1;
			end else if (i % 20 < 3) begin
				cpuAddr = 27'h0000100;
				cpuRdN  = 1'b0;
			end else if (i % 20 == 3) begin
				cpuAddr = 27'h0180000;
				cpuDqmN = 4'b1110;
			end
			checkCycle();
			if (i == 170) begin
				checkBit("dbgHook", dbgHook, 1'b1);
			end
		end
		checkBit("dbgHook", dbgHook, 1'b1);

		$display("TEST OK");
		$finish;
	end

endmodule

//--- saturnGlue_chk.sv
`timescale 1ns/100ps

module saturnGlue_chk (
	input logic CLK,
	input logic RST_N,
	input logic romCsN,
	input logic sramCsN,
	input logic smpcCsN,
	input logic ramlCsN,
	input logic ramhCsN,
	input logic ceR,
	input logic ceF,
	input logic mresN
);

	logic selFail = 1'b0;
	logic ceFail = 1'b0;
	logic mresFail = 1'b0;

	// Four or five selects high means at most one chip is addressed
	assert property (@(posedge CLK) disable iff (!RST_N)
		$countones({romCsN, sramCsN, smpcCsN, ramlCsN, ramhCsN}) >= 4)
	else begin
		$error("more than one chip select is active");
		selFail = 1'b1;
	end

	assert property (@(posedge CLK) disable iff (!RST_N) !(ceR && ceF))
	else begin
		$error("ceR and ceF are both high");
		ceFail = 1'b1;
	end

	// Master reset is released once and never taken back
	assert property (@(posedge CLK) disable iff (!RST_N) !$fell(mresN))
	else begin
		$error("mresN fell outside reset");
		mresFail = 1'b1;
	end

endmodule

//--- saturnGlue.sv
`timescale 1ns/100ps
`include "saturn_consts.svh"

module saturnGlue (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 dbgPause,

	input  saturnPkg::cpuAddr_t  cpuAddr,
	input  saturnPkg::busData_t  cpuDo,
	input  saturnPkg::dqm_t      cpuDqmN,
	input  logic                 cpuRdN,
	output saturnPkg::busData_t  cpuDi,
	output logic                 cpuWaitN,

	output saturnPkg::busAddr_t  memA,
	input  saturnPkg::busData_t  memDi,
	output saturnPkg::busData_t  memDo,
	output saturnPkg::dqm_t      memDqmN,
	output logic                 memRdN,
	input  logic                 memWaitN,
	output logic                 romCsN,
	output logic                 sramCsN,
	output logic                 smpcCsN,
	output logic                 ramlCsN,
	output logic                 ramhCsN,

	input  saturnPkg::smpcData_t smpcDo,
	input  saturnPkg::busData_t  scuDo,
	input  logic                 scuWaitN,

	output logic                 ceR,
	output logic                 ceF,
	output logic                 smpcCe,
	output logic                 mresN,

	output saturnPkg::dbgCount_t waitCnt,
	output logic                 dbgHook
);

	cpuBusIf bus ();

	assign bus.addr  = cpuAddr;
	assign bus.wdata = cpuDo;
	assign bus.dqmN  = cpuDqmN;
	assign bus.rdN   = cpuRdN;

	// Memory side sees the cycle without the area bits
	assign memA    = bus.addr[`BUS_ADDR_W-1:0];
	assign memDo   = bus.wdata;
	assign memDqmN = bus.dqmN;
	assign memRdN  = bus.rdN;

	clockEnableGen u_clockEnableGen (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.ce       (ce),
		.dbgPause (dbgPause),
		.ceR      (ceR),
		.ceF      (ceF),
		.smpcCe   (smpcCe),
		.mresN    (mresN)
	);

	cpuBusDecoder u_cpuBusDecoder (
		.bus      (bus.decoder),
		.memDi    (memDi),
		.smpcDo   (smpcDo),
		.scuDo    (scuDo),
		.memWaitN (memWaitN),
		.scuWaitN (scuWaitN),
		.romCsN   (romCsN),
		.sramCsN  (sramCsN),
		.smpcCsN  (smpcCsN),
		.ramlCsN  (ramlCsN),
		.ramhCsN  (ramhCsN),
		.cpuWaitN (cpuWaitN),
		.cpuDi    (cpuDi)
	);

	debugMonitor u_debugMonitor (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.ceR     (ceR),
		.bus     (bus.monitor),
		.waitCnt (waitCnt),
		.dbgHook (dbgHook)
	);

endmodule

//--- debugMonitor.sv
`timescale 1ns/100ps
`include "saturn_consts.svh"

module debugMonitor (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ceR,
	cpuBusIf.monitor             bus,
	output saturnPkg::dbgCount_t waitCnt,
	output logic                 dbgHook
);
	import saturnPkg::*;

	logic hookHit;

	// Boot code reading the hook word in high RAM
	assign hookHit = ~bus.rdN && (bus.region == regRamH) &&
	                 (bus.addr[`BUS_ADDR_W-1:0] == `HOOK_ADDR);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= '0;
			dbgHook <= 1'b0;
		end else if (ceR) begin
			// Master enables since the last access
			if (bus.access) begin
				waitCnt <= '0;
			end else begin
				waitCnt <= waitCnt + dbgCount_t'(1);
			end
			if (hookHit) begin
				dbgHook <= 1'b1;
			end
		end
	end

endmodule

//--- cpuBusDecoder.sv
`timescale 1ns/100ps
`include "saturn_consts.svh"

module cpuBusDecoder (
	cpuBusIf.decoder               bus,
	input  saturnPkg::busData_t    memDi,
	input  saturnPkg::smpcData_t   smpcDo,
	input  saturnPkg::busData_t    scuDo,
	input  logic                   memWaitN,
	input  logic                   scuWaitN,
	output logic                   romCsN,
	output logic                   sramCsN,
	output logic                   smpcCsN,
	output logic                   ramlCsN,
	output logic                   ramhCsN,
	output logic                   cpuWaitN,
	output saturnPkg::busData_t    cpuDi
);
	import saturnPkg::*;

	logic [`AREA_HI-`AREA_LO:0] areaField;
	logic [`SUB_HI-`SUB_LO:0]   subField;
	logic                       access;
	memRegion_e                 region;
	logic                       memSel;

	assign areaField = bus.addr[`AREA_HI:`AREA_LO];
	assign subField  = bus.addr[`SUB_HI:`SUB_LO];

	// A cycle is live on a read or any byte write
	assign access = ~bus.rdN | ~(&bus.dqmN);

	always_comb begin
		region = regNone;
		if (access) begin
			case (areaField)
				`AREA_CS3: begin
					region = regRamH;
				end
				`AREA_CS0: begin
					if (subField <= `SUB_ROM_MAX) begin
						region = regRom;
					end else if (subField == `SUB_SMPC) begin
						region = regSmpc;
					end else if (subField == `SUB_SRAM) begin
						region = regSram;
					end else if (subField >= `SUB_RAML_LO && subField <= `SUB_RAML_HI) begin
						region = regRamL;
					end else begin
						region = regScu;
					end
				end
				// CS1 and CS2 belong to the SCU
				default: begin
					region = regScu;
				end
			endcase
		end
	end

	assign bus.access = access;
	assign bus.region = region;

	assign romCsN  = (region != regRom);
	assign sramCsN = (region != regSram);
	assign smpcCsN = (region != regSmpc);
	assign ramlCsN = (region != regRamL);
	assign ramhCsN = (region != regRamH);

	// External memories share one data bus and one wait line
	assign memSel = (region == regRom) | (region == regSram) |
	                (region == regRamL) | (region == regRamH);

	always_comb begin
		if (memSel) begin
			cpuDi = memDi;
		end else if (region == regSmpc) begin
			cpuDi = {(`DATA_W / `SMPC_W){smpcDo}};
		end else begin
			cpuDi = scuDo;
		end
	end

	assign cpuWaitN = scuWaitN & (memWaitN | ~memSel);

endmodule

//--- clockEnableGen.sv
`timescale 1ns/100ps
`include "saturn_consts.svh"

module clockEnableGen (
	input  logic CLK,
	input  logic RST_N,
	input  logic ce,
	input  logic dbgPause,
	output logic ceR,
	output logic ceF,
	output logic smpcCe,
	output logic mresN
);

	localparam int CNT_W = $clog2(`SMPC_DIV);

	logic             phase;
	logic             run;
	logic [CNT_W-1:0] smpcCnt;

	// Master clock runs only while not paused
	assign run = ce & ~dbgPause;
	assign ceF = run & ~phase;
	assign ceR = run & phase;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			phase <= 1'b0;
		end else if (run) begin
			phase <= ~phase;
		end
	end

	// SMPC enable, one pulse every SMPC_DIV rising enables
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			smpcCnt <= '0;
			smpcCe  <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceR) begin
				if (smpcCnt == CNT_W'(`SMPC_DIV - 1)) begin
					smpcCnt <= '0;
					smpcCe  <= 1'b1;
				end else begin
					smpcCnt <= smpcCnt + 1'b1;
				end
			end
		end
	end

	// Master reset released by the first SMPC enable
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mresN <= 1'b0;
		end else if (smpcCe) begin
			mresN <= 1'b1;
		end
	end

endmodule

//--- cpuBusIf.sv
`timescale 1ns/100ps

interface cpuBusIf;
	import saturnPkg::*;

	// Raw CPU cycle
	cpuAddr_t   addr;
	busData_t   wdata;
	dqm_t       dqmN;
	logic       rdN;

	// Decoded view of the cycle
	memRegion_e region;
	logic       access;

	modport decoder (
		input  addr,
		input  dqmN,
		input  rdN,
		output region,
		output access
	);

	modport monitor (
		input  addr,
		input  rdN,
		input  region,
		input  access
	);

endinterface

//--- saturnPkg.sv
`include "saturn_consts.svh"

package saturnPkg;

	// Full CPU address, area included
	typedef logic [`CPU_ADDR_W-1:0] cpuAddr_t;

	// Address as seen by the external memories
	typedef logic [`BUS_ADDR_W-1:0] busAddr_t;

	typedef logic [`DATA_W-1:0] busData_t;

	// Byte write strobes, active low
	typedef logic [`DQM_W-1:0] dqm_t;

	typedef logic [`SMPC_W-1:0] smpcData_t;

	typedef logic [`DBG_CNT_W-1:0] dbgCount_t;

	// Target of the current CPU cycle
	typedef enum logic [2:0] {
		regNone,
		regRom,
		regSram,
		regSmpc,
		regRamL,
		regRamH,
		regScu
	} memRegion_e;

endpackage

//--- saturn_consts.svh
`ifndef SATURN_CONSTS_SVH
`define SATURN_CONSTS_SVH

// Bus widths
`define CPU_ADDR_W   27
`define BUS_ADDR_W   25
`define DATA_W       32
`define DQM_W        4
`define SMPC_W       8
`define DBG_CNT_W    8

// Area field of the CPU address, one area per CS line
`define AREA_HI      26
`define AREA_LO      25
`define AREA_CS0     2'd0
`define AREA_CS3     2'd3

// CS0 sub-region field, 512 KB granularity
`define SUB_HI       24
`define SUB_LO       19
`define SUB_ROM_MAX  6'd1
`define SUB_SMPC     6'd2
`define SUB_SRAM     6'd3
`define SUB_RAML_LO  6'd4
`define SUB_RAML_HI  6'd5

// ceR pulses per SMPC enable
`define SMPC_DIV     7

// Boot hook location in high RAM
`define HOOK_ADDR    25'h0012B0

`endif
